//--- rtl/lsu_pkg.sv
/* Shared widths and encodings for the load/store unit.
   The DCCM word is fixed at 32 bits, so the byte offset is always 2 bits wide */
`default_nettype none

package lsu_pkg;

  // ****************************************
  // Widths
  // ****************************************

  localparam int xlen       = 32;  // Data path width
  localparam int word_bytes = 4;   // Bytes per DCCM word
  localparam int off_bits   = 2;   // Byte offset within a word

  // ****************************************
  // Encodings
  // ****************************************

  // Request operation
  typedef enum logic [1:0] {
    op_none  = 2'd0,  // Bubble, nothing to do
    op_load  = 2'd1,
    op_store = 2'd2
  } lsu_op_e;

  // Access size, naturally aligned only
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } lsu_size_e;

endpackage

`default_nettype wire

//--- rtl/lsu_addr_gen.sv
/* dc1 stage. Assumes naturally aligned accesses and a word aligned dccm_base */
`timescale 1ns/1ps
`default_nettype none

module lsu_addr_gen #(
  parameter logic [lsu_pkg::xlen-1:0] dccm_base      = 32'hf004_0000,
  parameter int                       dccm_addr_bits = 10
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               lsu_valid,       // One request per strobe
  input  lsu_pkg::lsu_op_e                   lsu_op,
  input  lsu_pkg::lsu_size_e                 lsu_size,
  input  logic                               lsu_unsigned,
  input  logic [lsu_pkg::xlen-1:0]           rs1,
  input  logic [11:0]                        offset,
  input  logic [lsu_pkg::xlen-1:0]           store_data,
  output logic                               dc2_valid,
  output lsu_pkg::lsu_op_e                   dc2_op,
  output lsu_pkg::lsu_size_e                 dc2_size,
  output logic                               dc2_unsigned,
  output logic [dccm_addr_bits-1:0]          dc2_word_addr,
  output logic [lsu_pkg::off_bits-1:0]       dc2_byte_off,
  output logic [lsu_pkg::xlen-1:0]           dc2_store_data,  // Already in its byte lane
  output logic                               dc2_error,       // Outside the DCCM region
  output logic [lsu_pkg::xlen-1:0]           dc2_addr
);

  import lsu_pkg::*;

  logic [xlen-1:0] addr;        // Effective address
  logic [xlen-1:0] rel;         // Offset from the region base
  logic            in_dccm;
  logic [xlen-1:0] store_lane;

  // ****************************************
  // Address and region check
  // ****************************************

  assign addr = rs1 + {{(xlen-12){offset[11]}}, offset};  // Sign extended offset
  assign rel  = addr - dccm_base;  // Wraps below base, so one compare covers both ends

  // Inside when no bit above the DCCM byte range is set
  assign in_dccm = (rel >> (dccm_addr_bits + off_bits)) == '0;

  // Move store bytes into the lane they will be written to
  assign store_lane = store_data << {rel[off_bits-1:0], 3'b000};

  // ****************************************
  // dc2 packet
  // ****************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      dc2_valid <= 1'b0;
    end else begin
      dc2_valid <= lsu_valid & (lsu_op != op_none);  // Bubbles never enter dc2
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_valid) begin
      dc2_op         <= lsu_op;
      dc2_size       <= lsu_size;
      dc2_unsigned   <= lsu_unsigned;
      dc2_word_addr  <= rel[dccm_addr_bits+off_bits-1:off_bits];
      dc2_byte_off   <= rel[off_bits-1:0];
      dc2_store_data <= store_lane;
      dc2_error      <= ~in_dccm;
      dc2_addr       <= addr;  // Kept for error reporting
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_dccm_rd.sv
/* dc2 read side. The DCCM registers read data, so it returns in dc3 */
`timescale 1ns/1ps
`default_nettype none

module lsu_dccm_rd #(
  parameter int dccm_addr_bits = 10
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         dc2_valid,
  input  lsu_pkg::lsu_op_e             dc2_op,
  input  lsu_pkg::lsu_size_e           dc2_size,
  input  logic                         dc2_unsigned,
  input  logic [dccm_addr_bits-1:0]    dc2_word_addr,
  input  logic [lsu_pkg::off_bits-1:0] dc2_byte_off,
  input  logic                         dc2_error,
  input  logic [lsu_pkg::xlen-1:0]     dc2_addr,
  output logic                         dccm_rden,
  output logic [dccm_addr_bits-1:0]    dccm_rd_addr,
  output logic                         dc3_valid,     // Good load in dc3
  output lsu_pkg::lsu_size_e           dc3_size,
  output logic                         dc3_unsigned,
  output logic [lsu_pkg::off_bits-1:0] dc3_byte_off,
  output logic                         dc3_error,     // Errored load or store in dc3
  output logic [lsu_pkg::xlen-1:0]     dc3_addr
);

  import lsu_pkg::*;

  logic rd_go;  // Load that really reads the DCCM

  assign rd_go        = dc2_valid & (dc2_op == op_load) & ~dc2_error;
  assign dccm_rden    = rd_go;
  assign dccm_rd_addr = dc2_word_addr;

  // Only point where an access error turns into a report
  always_ff @(posedge clk) begin
    if (rst) begin
      dc3_valid <= 1'b0;
      dc3_error <= 1'b0;
    end else begin
      dc3_valid <= rd_go;
      dc3_error <= dc2_valid & dc2_error;  // Stores report too
    end
  end

  always_ff @(posedge clk) begin
    dc3_size     <= dc2_size;
    dc3_unsigned <= dc2_unsigned;
    dc3_byte_off <= dc2_byte_off;
    dc3_addr     <= dc2_addr;
  end

endmodule

`default_nettype wire

//--- rtl/lsu_stbuf.sv
/* Store buffer, drains one entry per cycle while non-empty.
   Caller must hold stores off while lsu_store_stall is high */
`timescale 1ns/1ps
`default_nettype none

module lsu_stbuf #(
  parameter int dccm_addr_bits = 10,
  parameter int stbuf_depth    = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           dc2_valid,
  input  lsu_pkg::lsu_op_e               dc2_op,
  input  lsu_pkg::lsu_size_e             dc2_size,
  input  logic [dccm_addr_bits-1:0]      dc2_word_addr,
  input  logic [lsu_pkg::off_bits-1:0]   dc2_byte_off,
  input  logic [lsu_pkg::xlen-1:0]       dc2_store_data,
  input  logic                           dc2_error,
  output logic                           dccm_wren,
  output logic [dccm_addr_bits-1:0]      dccm_wr_addr,
  output logic [lsu_pkg::xlen-1:0]       dccm_wr_data,
  output logic [lsu_pkg::word_bytes-1:0] dccm_wr_byteen,
  output logic [lsu_pkg::xlen-1:0]       dc3_fwd_data,
  output logic [lsu_pkg::word_bytes-1:0] dc3_fwd_byteen,
  output logic                           lsu_store_stall,
  output logic                           stbuf_empty
);

  import lsu_pkg::*;

  localparam int ptr_w = (stbuf_depth > 1) ? $clog2(stbuf_depth) : 1;
  localparam int cnt_w = $clog2(stbuf_depth + 1);

  logic [dccm_addr_bits-1:0] addr_q   [stbuf_depth];  // Word address per entry
  logic [word_bytes-1:0]     byteen_q [stbuf_depth];
  logic [xlen-1:0]           data_q   [stbuf_depth];

  logic [ptr_w-1:0]      head;        // Oldest entry, next to drain
  logic [ptr_w-1:0]      tail;        // Next free slot
  logic [cnt_w-1:0]      count;
  logic                  is_store;
  logic                  alloc;
  logic                  drain;
  logic [word_bytes-1:0] new_byteen;
  logic [xlen-1:0]       fwd_data;
  logic [word_bytes-1:0] fwd_byteen;

  // Wrap at depth, works for any depth
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    ptr_inc = (p == ptr_w'(stbuf_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ****************************************
  // Allocate and drain
  // ****************************************

  assign is_store = dc2_valid & (dc2_op == op_store);
  assign alloc    = is_store & ~dc2_error;  // Errored stores are dropped
  assign drain    = count != '0;

  always_comb begin
    case (dc2_size)
      size_byte: new_byteen = {{(word_bytes-1){1'b0}}, 1'b1} << dc2_byte_off;
      size_half: new_byteen = {{(word_bytes-2){1'b0}}, 2'b11} << dc2_byte_off;
      size_word: new_byteen = '1;
      default:   new_byteen = '0;
    endcase
  end

  assign dccm_wren      = drain;
  assign dccm_wr_addr   = addr_q[head];
  assign dccm_wr_data   = data_q[head];
  assign dccm_wr_byteen = byteen_q[head];

  assign stbuf_empty     = count == '0;
  // Full, or about to be filled by the store now in dc2
  assign lsu_store_stall = (count == cnt_w'(stbuf_depth)) |
                           ((count == cnt_w'(stbuf_depth - 1)) & is_store);

  // ****************************************
  // Forwarding to dc2 loads
  // ****************************************

  // Walk oldest to youngest so younger bytes win
  always_comb begin
    int idx;
    fwd_data   = '0;
    fwd_byteen = '0;
    for (int i = 0; i < stbuf_depth; i++) begin
      idx = (int'(head) + i) % stbuf_depth;
      if ((i < int'(count)) && dc2_valid && (dc2_op == op_load) &&
          (addr_q[idx] == dc2_word_addr)) begin
        for (int b = 0; b < word_bytes; b++) begin
          if (byteen_q[idx][b]) begin
            fwd_byteen[b]       = 1'b1;
            fwd_data[8*b +: 8] = data_q[idx][8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      dc3_fwd_byteen <= '0;
    end else begin
      if (alloc) tail <= ptr_inc(tail);
      if (drain) head <= ptr_inc(head);
      count          <= count + cnt_w'(alloc) - cnt_w'(drain);
      dc3_fwd_byteen <= fwd_byteen;  // Zero unless a load hit
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      addr_q[tail]   <= dc2_word_addr;
      byteen_q[tail] <= new_byteen;
      data_q[tail]   <= dc2_store_data;
    end
    dc3_fwd_data <= fwd_data;
  end

endmodule

`default_nettype wire

//--- rtl/lsu_load_align.sv
/* dc3 merge, align and extend. Result and error are one-cycle pulses */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           dc3_valid,
  input  lsu_pkg::lsu_size_e             dc3_size,
  input  logic                           dc3_unsigned,
  input  logic [lsu_pkg::off_bits-1:0]   dc3_byte_off,
  input  logic                           dc3_error,
  input  logic [lsu_pkg::xlen-1:0]       dc3_addr,
  input  logic [lsu_pkg::xlen-1:0]       dccm_rd_data,
  input  logic [lsu_pkg::xlen-1:0]       dc3_fwd_data,
  input  logic [lsu_pkg::word_bytes-1:0] dc3_fwd_byteen,
  output logic                           lsu_result_valid,
  output logic [lsu_pkg::xlen-1:0]       lsu_result,
  output logic                           lsu_error,
  output logic [lsu_pkg::xlen-1:0]       lsu_error_addr
);

  import lsu_pkg::*;

  logic [xlen-1:0] merged;   // Buffer bytes over memory bytes
  logic [xlen-1:0] shifted;  // Addressed byte moved to bit 0
  logic [xlen-1:0] ext;

  always_comb begin
    for (int b = 0; b < word_bytes; b++) begin
      merged[8*b +: 8] = dc3_fwd_byteen[b] ? dc3_fwd_data[8*b +: 8] : dccm_rd_data[8*b +: 8];
    end
    shifted = merged >> {dc3_byte_off, 3'b000};
    case (dc3_size)
      size_byte: ext = {{(xlen-8){~dc3_unsigned & shifted[7]}}, shifted[7:0]};
      size_half: ext = {{(xlen-16){~dc3_unsigned & shifted[15]}}, shifted[15:0]};
      default:   ext = shifted;  // Word
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lsu_result_valid <= 1'b0;
      lsu_error        <= 1'b0;
    end else begin
      lsu_result_valid <= dc3_valid;
      lsu_error        <= dc3_error;
    end
  end

  always_ff @(posedge clk) begin
    if (dc3_valid) lsu_result <= ext;
    if (dc3_error) lsu_error_addr <= dc3_addr;  // Holds the last errored address
  end

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
/* Load/store unit, dc1 to dc3, three edges from request to result.
   Aligned DCCM accesses only; no store may be presented while lsu_store_stall is high */
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter logic [lsu_pkg::xlen-1:0] dccm_base      = 32'hf004_0000,
  parameter int                       dccm_addr_bits = 10,  // 4 KiB
  parameter int                       stbuf_depth    = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           lsu_valid,
  input  lsu_pkg::lsu_op_e               lsu_op,
  input  lsu_pkg::lsu_size_e             lsu_size,
  input  logic                           lsu_unsigned,
  input  logic [lsu_pkg::xlen-1:0]       rs1,
  input  logic [11:0]                    offset,
  input  logic [lsu_pkg::xlen-1:0]       store_data,
  output logic                           lsu_result_valid,
  output logic [lsu_pkg::xlen-1:0]       lsu_result,
  output logic                           lsu_error,
  output logic [lsu_pkg::xlen-1:0]       lsu_error_addr,
  output logic                           lsu_store_stall,
  output logic                           lsu_idle,
  output logic                           dccm_rden,
  output logic [dccm_addr_bits-1:0]      dccm_rd_addr,
  input  logic [lsu_pkg::xlen-1:0]       dccm_rd_data,
  output logic                           dccm_wren,
  output logic [dccm_addr_bits-1:0]      dccm_wr_addr,
  output logic [lsu_pkg::xlen-1:0]       dccm_wr_data,
  output logic [lsu_pkg::word_bytes-1:0] dccm_wr_byteen
);

  import lsu_pkg::*;

  // dc2 packet
  logic                      dc2_valid;
  lsu_op_e                   dc2_op;
  lsu_size_e                 dc2_size;
  logic                      dc2_unsigned;
  logic [dccm_addr_bits-1:0] dc2_word_addr;
  logic [off_bits-1:0]       dc2_byte_off;
  logic [xlen-1:0]           dc2_store_data;
  logic                      dc2_error;
  logic [xlen-1:0]           dc2_addr;

  // dc3 packet and forwarding
  logic                  dc3_valid;
  lsu_size_e             dc3_size;
  logic                  dc3_unsigned;
  logic [off_bits-1:0]   dc3_byte_off;
  logic                  dc3_error;
  logic [xlen-1:0]       dc3_addr;
  logic [xlen-1:0]       dc3_fwd_data;
  logic [word_bytes-1:0] dc3_fwd_byteen;
  logic                  stbuf_empty;

  lsu_addr_gen #(
    .dccm_base      (dccm_base),
    .dccm_addr_bits (dccm_addr_bits)
  ) addr_gen_i (
    .clk, .rst, .lsu_valid, .lsu_op, .lsu_size, .lsu_unsigned, .rs1, .offset, .store_data,
    .dc2_valid, .dc2_op, .dc2_size, .dc2_unsigned, .dc2_word_addr, .dc2_byte_off,
    .dc2_store_data, .dc2_error, .dc2_addr
  );

  lsu_dccm_rd #(
    .dccm_addr_bits (dccm_addr_bits)
  ) dccm_rd_i (
    .clk, .rst, .dc2_valid, .dc2_op, .dc2_size, .dc2_unsigned, .dc2_word_addr,
    .dc2_byte_off, .dc2_error, .dc2_addr, .dccm_rden, .dccm_rd_addr,
    .dc3_valid, .dc3_size, .dc3_unsigned, .dc3_byte_off, .dc3_error, .dc3_addr
  );

  lsu_stbuf #(
    .dccm_addr_bits (dccm_addr_bits),
    .stbuf_depth    (stbuf_depth)
  ) stbuf_i (
    .clk, .rst, .dc2_valid, .dc2_op, .dc2_size, .dc2_word_addr, .dc2_byte_off,
    .dc2_store_data, .dc2_error, .dccm_wren, .dccm_wr_addr, .dccm_wr_data, .dccm_wr_byteen,
    .dc3_fwd_data, .dc3_fwd_byteen, .lsu_store_stall, .stbuf_empty
  );

  lsu_load_align load_align_i (
    .clk, .rst, .dc3_valid, .dc3_size, .dc3_unsigned, .dc3_byte_off, .dc3_error, .dc3_addr,
    .dccm_rd_data, .dc3_fwd_data, .dc3_fwd_byteen,
    .lsu_result_valid, .lsu_result, .lsu_error, .lsu_error_addr
  );

  // Nothing buffered and nothing in flight past dc1
  assign lsu_idle = stbuf_empty & ~(dc2_valid | dc3_valid | dc3_error);

endmodule

`default_nettype wire

//--- test/lsu_tb_model.svh
/* Reference model, included inside the testbench module body.
   Memory follows program order at acceptance, so buffered stores are already visible here */
`default_nettype none
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

  localparam logic [31:0] dccm_lo   = 32'hf004_0000;  // DUT default base
  localparam int          dccm_size = 4096;           // Bytes

  logic [7:0]  arch_mem [dccm_size];  // Architectural byte memory
  int          due_q [$];             // Edge count at which the outcome is visible
  int          kind_q [$];            // 1 load result, 2 access error
  logic [31:0] val_q [$];             // Load value or error address

  // Fill pattern, different for every word
  function automatic logic [31:0] fill_word(input int w);
    return {w[9:0], 6'h2b, ~w[9:0], 6'h15} ^ (32'h9e37_79b9 * (w + 1));
  endfunction

  function automatic int size_bytes(input lsu_size_e sz);
    case (sz)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic logic in_region(input logic [31:0] a);
    return (a >= dccm_lo) && (a < dccm_lo + dccm_size);
  endfunction

  function automatic logic [31:0] arch_word(input int w);
    return {arch_mem[4*w+3], arch_mem[4*w+2], arch_mem[4*w+1], arch_mem[4*w]};
  endfunction

  task automatic model_init();
    logic [31:0] f;
    for (int w = 0; w < dccm_size / 4; w++) begin
      f = fill_word(w);
      for (int b = 0; b < 4; b++) begin
        arch_mem[4*w+b] = f[8*b +: 8];  // Little endian
      end
    end
  endtask

  // Little endian gather, then sign or zero extension
  function automatic logic [31:0] predict_load(input logic [31:0] a, input lsu_size_e sz,
                                               input logic uns);
    logic [31:0] v;
    int          n;
    n = size_bytes(sz);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v[8*b +: 8] = arch_mem[a - dccm_lo + b];
    end
    if (!uns && v[8*n-1]) begin
      for (int b = n; b < 4; b++) begin
        v[8*b +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  // Good stores update memory and show nothing at the outputs
  task automatic model_request(input lsu_op_e op, input lsu_size_e sz, input logic uns,
                               input logic [31:0] a, input logic [31:0] data, input int due);
    int n;
    n = size_bytes(sz);
    if (!in_region(a)) begin
      due_q.push_back(due);
      kind_q.push_back(2);
      val_q.push_back(a);
    end else if (op == op_load) begin
      due_q.push_back(due);
      kind_q.push_back(1);
      val_q.push_back(predict_load(a, sz, uns));
    end else begin
      for (int b = 0; b < n; b++) begin
        arch_mem[a - dccm_lo + b] = data[8*b +: 8];  // Low bytes of the unshifted data
      end
    end
  endtask

`endif
`default_nettype wire

//--- test/tb_lsu.sv
/* Randomized testbench for lsu_top at default parameters.
   Outputs are sampled at the falling edge; stores are held back while the stall is high */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  `include "lsu_tb_model.svh"

  localparam int n_fill      = 80;  // Requests per test
  localparam int n_fwd       = 80;
  localparam int n_err       = 40;
  localparam int n_burst     = 60;
  localparam int cycle_limit = (n_fill + n_fwd + n_err + n_burst) * 4 + 200;

  logic        clk;
  logic        rst;
  logic        lsu_valid;
  lsu_op_e     lsu_op;
  lsu_size_e   lsu_size;
  logic        lsu_unsigned;
  logic [31:0] rs1;
  logic [11:0] offset;
  logic [31:0] store_data;
  logic        lsu_result_valid;
  logic [31:0] lsu_result;
  logic        lsu_error;
  logic [31:0] lsu_error_addr;
  logic        lsu_store_stall;
  logic        lsu_idle;
  logic        dccm_rden;
  logic [9:0]  dccm_rd_addr;
  logic [31:0] dccm_rd_data = '0;
  logic        dccm_wren;
  logic [9:0]  dccm_wr_addr;
  logic [31:0] dccm_wr_data;
  logic [3:0]  dccm_wr_byteen;

  logic [31:0] dccm_mem [1024];  // DCCM word array
  logic [31:0] lfsr;
  int          cycles = 0;       // Rising edges so far
  int          n_checks = 0;
  int          n_errors = 0;
  int          t_checks;
  int          t_errors;
  string       cur_test = "reset";

  lsu_top dut_i (
    .clk, .rst, .lsu_valid, .lsu_op, .lsu_size, .lsu_unsigned, .rs1, .offset, .store_data,
    .lsu_result_valid, .lsu_result, .lsu_error, .lsu_error_addr, .lsu_store_stall, .lsu_idle,
    .dccm_rden, .dccm_rd_addr, .dccm_rd_data, .dccm_wren, .dccm_wr_addr, .dccm_wr_data,
    .dccm_wr_byteen
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // ****************************************
  // DCCM model and run limit
  // ****************************************

  // Registered read; same-word write in the same cycle returns old data
  always @(posedge clk) begin
    if (dccm_rden) dccm_rd_data <= dccm_mem[dccm_rd_addr];
    if (dccm_wren) begin
      for (int b = 0; b < 4; b++) begin
        if (dccm_wr_byteen[b]) dccm_mem[dccm_wr_addr][8*b +: 8] <= dccm_wr_data[8*b +: 8];
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run passed %0d cycles without finishing", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ****************************************
  // Helpers
  // ****************************************

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = lfsr_bits(1);
    return r[0];
  endfunction

  function automatic lsu_size_e rand_size();
    logic [31:0] r;
    r = lfsr_bits(2);
    if (r == 0) return size_byte;
    else if (r == 1) return size_half;
    return size_word;  // Word twice as likely
  endfunction

  // Random naturally aligned lane inside a word-aligned address
  function automatic logic [31:0] lane_addr(input logic [31:0] w, input lsu_size_e sz);
    case (sz)
      size_byte: return w + lfsr_bits(2);
      size_half: return w + (lfsr_bits(1) << 1);
      default:   return w;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    t_checks++;
    if (exp !== act) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      n_errors++;
      t_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    t_checks = 0;
    t_errors = 0;
  endtask

  task automatic end_test();
    if (due_q.size() != 0) begin
      $display("%s: expected outputs never showed up", cur_test);
      n_errors++;
      t_errors++;
    end
    $display("%s: done, %0d checks, %0d errors", cur_test, t_checks, t_errors);
  endtask

  task automatic check_quiet();
    check({cur_test, " idle"}, 1, lsu_idle);
    check({cur_test, " result_valid"}, 0, lsu_result_valid);
    check({cur_test, " error"}, 0, lsu_error);
    check({cur_test, " rden"}, 0, dccm_rden);
    check({cur_test, " wren"}, 0, dccm_wren);
    check({cur_test, " store_stall"}, 0, lsu_store_stall);
  endtask

  // Called just after an edge; split the address into rs1 plus a random offset
  task automatic issue(input lsu_op_e op, input lsu_size_e sz, input logic uns,
                       input logic [31:0] a, input logic [31:0] data);
    logic [31:0] r;
    r = lfsr_bits(12);
    while (op == op_store && lsu_store_stall) begin
      @(posedge clk);
      #1;
    end
    lsu_valid    = 1'b1;
    lsu_op       = op;
    lsu_size     = sz;
    lsu_unsigned = uns;
    offset       = r[11:0];
    rs1          = a - {{20{r[11]}}, r[11:0]};
    store_data   = data;
    model_request(op, sz, uns, a, data, cycles + 3);  // Accepted next edge, seen 2 edges on
    @(posedge clk);
    #1;
    lsu_valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (!lsu_idle) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);  // Let the last output pulse be sampled
    #1;
  endtask

  // ****************************************
  // Output monitor
  // ****************************************

  always @(negedge clk) begin
    if (!rst) begin
      if (due_q.size() > 0 && due_q[0] == cycles) begin
        check({cur_test, " result_valid"}, (kind_q[0] == 1), lsu_result_valid);
        check({cur_test, " error"}, (kind_q[0] == 2), lsu_error);
        if (kind_q[0] == 1) check({cur_test, " result"}, val_q[0], lsu_result);
        else check({cur_test, " error_addr"}, val_q[0], lsu_error_addr);
        void'(due_q.pop_front());
        void'(kind_q.pop_front());
        void'(val_q.pop_front());
      end else begin
        check({cur_test, " result_valid"}, 0, lsu_result_valid);  // No stray pulses
        check({cur_test, " error"}, 0, lsu_error);
      end
    end
  end

  // ****************************************
  // Tests
  // ****************************************

  initial begin
    lsu_size_e   sz;
    logic [31:0] a;
    int          n;
    int          k;
    rst          = 1'b1;
    lsu_valid    = 1'b0;
    lsu_op       = op_none;
    lsu_size     = size_byte;
    lsu_unsigned = 1'b0;
    rs1          = '0;
    offset       = '0;
    store_data   = '0;
    lfsr         = 32'heb2b99b0;
    model_init();
    for (int w = 0; w < dccm_size / 4; w++) begin
      dccm_mem[w] = fill_word(w);
    end
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("reset_idle");
    check_quiet();
    end_test();

    // Stores drain first, so loads read the DCCM
    begin_test("aligned_loads");
    for (int i = 0; i < n_fill / 2 - 8; i++) begin
      sz = rand_size();
      issue(op_store, sz, 1'b0, lane_addr(dccm_lo + (lfsr_bits(4) << 2), sz), lfsr_bits(32));
    end
    wait_idle();
    for (int i = 0; i < n_fill / 2 + 8; i++) begin
      sz = rand_size();
      issue(op_load, sz, rand_bit(), lane_addr(dccm_lo + (lfsr_bits(4) << 2), sz), '0);
    end
    wait_idle();
    end_test();

    // One to four stores to a word, then a load right behind them
    begin_test("store_forward");
    n = 0;
    while (n < n_fwd) begin
      a = dccm_lo + (lfsr_bits(4) << 2);
      k = lfsr_bits(2) + 1;
      for (int j = 0; j < k; j++) begin
        sz = rand_size();
        issue(op_store, sz, 1'b0, lane_addr(a, sz), lfsr_bits(32));
      end
      sz = rand_size();
      issue(op_load, sz, rand_bit(), lane_addr(a, sz), '0);
      n = n + k + 1;
    end
    wait_idle();
    end_test();

    begin_test("region_error");
    for (int i = 0; i < n_err; i++) begin
      sz = rand_size();
      k  = lfsr_bits(2);
      case (k)
        0:       a = dccm_lo - ((lfsr_bits(8) + 1) << 2);           // Below the base
        1:       a = dccm_lo + dccm_size + (lfsr_bits(8) << 2);     // Past the top
        2:       a = lfsr_bits(32) & 32'hffff_fffc;                 // Anywhere
        default: a = dccm_lo + (lfsr_bits(4) << 2);  // Good load, sees no errored store
      endcase
      if (k == 3 || rand_bit()) issue(op_load, sz, rand_bit(), lane_addr(a, sz), '0);
      else issue(op_store, sz, 1'b0, lane_addr(a, sz), lfsr_bits(32));
    end
    wait_idle();
    end_test();

    // Back to back stores over the whole DCCM, then compare every word
    begin_test("store_burst");
    for (int i = 0; i < n_burst; i++) begin
      sz = rand_size();
      issue(op_store, sz, 1'b0, lane_addr(dccm_lo + (lfsr_bits(10) << 2), sz), lfsr_bits(32));
    end
    wait_idle();
    for (int w = 0; w < dccm_size / 4; w++) begin
      check({cur_test, " memory"}, arch_word(w), dccm_mem[w]);
    end
    end_test();

    begin_test("idle_after_drain");
    wait_idle();
    check_quiet();
    repeat (4) @(posedge clk);
    #1;
    check_quiet();
    end_test();

    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
rtl/lsu_pkg.sv
rtl/lsu_addr_gen.sv
rtl/lsu_dccm_rd.sv
rtl/lsu_stbuf.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
test/tb_lsu.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_addr_gen.sv
  - rtl/lsu_dccm_rd.sv
  - rtl/lsu_stbuf.sv
  - rtl/lsu_load_align.sv
  - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_lsu.sv
